//--- bench/retire_tb.sv
`timescale 1ns/1ps

module retire_tb;
    import retire_pkg::*;

    logic                           clock;
    logic                           reset;
    logic                           dispatch_en;
    logic [ar_bits-1:0]             dispatch_arch_reg;
    logic [pr_bits-1:0]             dispatch_told;
    logic [pr_bits-1:0]             dispatch_tnew;
    logic [rob_bits-1:0]            dispatch_rob_idx;
    logic                           rob_full;
    logic                           complete_en;
    logic [rob_bits-1:0]            complete_rob_idx;
    logic                           complete_mispredict;
    logic [xlen-1:0]                complete_target_pc;
    logic                           recover_en;
    logic [xlen-1:0]                target_pc;
    logic [ar_num-1:0][pr_bits-1:0] recover_maptable;
    logic [1:0]                     retire_count;
    logic [ar_num-1:0][pr_bits-1:0] arch_map;

    // reference model, mirrors the state after the coming edge
    logic                           m_done [rob_size];
    logic                           m_bad  [rob_size];
    logic [ar_bits-1:0]             m_ar   [rob_size];
    logic [pr_bits-1:0]             m_tnew [rob_size];
    logic [pr_bits-1:0]             m_told [rob_size];
    logic [xlen-1:0]                m_pc   [rob_size];
    int                             m_head;
    int                             m_count;
    logic [ar_num-1:0][pr_bits-1:0] m_map;
    logic [ar_num-1:0][pr_bits-1:0] spec_map;  // rename state, source of told
    logic [pr_bits-1:0]             m_fl [fl_size];
    int                             m_fl_head;
    int                             m_fl_tail;
    int                             errors;
    integer                         seed;

    retire_top UUT (.*);

    always #5 clock = ~clock;

    task automatic check(input logic [255:0] act, input logic [255:0] exp, input string what);
        if (act !== exp) begin
            errors++;
            $display("Error at %0t: %s, got %0h expected %0h", $time, what, act, exp);
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timeout: %s", what);
        $display("test failed");
        $finish;
    endtask

    function automatic int tail_idx();
        return (m_head + m_count) % rob_size;
    endfunction

    // leading run of completed entries, a mispredict ends it
    function automatic int retire_num();
        int  n;
        int  idx;
        logic stop;
        n = 0;
        stop = 1'b0;
        for (int i = 0; i < retire_width; i++) begin
            idx = (m_head + i) % rob_size;
            if (!stop && i < m_count && m_done[idx]) begin
                n++;
                stop = m_bad[idx];
            end
            else begin
                stop = 1'b1;
            end
        end
        return n;
    endfunction

    function automatic logic recovers(input int n);
        return n > 0 && m_bad[(m_head + n - 1) % rob_size];  // last retired one
    endfunction

    // committed map plus retiring writes, oldest first
    function automatic logic [ar_num-1:0][pr_bits-1:0] recovered_map(input int n);
        logic [ar_num-1:0][pr_bits-1:0] res;
        int idx;
        res = m_map;
        for (int i = 0; i < n; i++) begin
            idx = (m_head + i) % rob_size;
            if (m_ar[idx] != 0)
                res[m_ar[idx]] = m_tnew[idx];
        end
        return res;
    endfunction

    task automatic model_reset();
        m_head = 0;
        m_count = 0;
        m_fl_head = 0;
        m_fl_tail = 0;  // free list starts full
        for (int i = 0; i < rob_size; i++)
            m_done[i] = 1'b0;
        for (int i = 0; i < ar_num; i++) begin
            m_map[i] = pr_bits'(i);
            spec_map[i] = pr_bits'(i);
        end
        for (int i = 0; i < fl_size; i++)
            m_fl[i] = pr_bits'(32 + i);
    endtask

    task automatic compare_outputs();
        int   n;
        int   last;
        logic rec;
        n = retire_num();
        rec = recovers(n);
        last = (m_head + n + rob_size - 1) % rob_size;
        check(retire_count, n, "retire_count");
        check(recover_en, rec, "recover_en");
        check(target_pc, rec ? m_pc[last] : '0, "target_pc");
        check(recover_maptable, recovered_map(n), "recover_maptable");
        check(arch_map, m_map, "arch_map");
        check(rob_full, m_count == rob_size, "rob_full");
        if (dispatch_en)
            check(dispatch_rob_idx, tail_idx(), "dispatch_rob_idx");
        if (dispatch_en && m_count < rob_size)
            check(dispatch_tnew, dispatch_arch_reg != 0 ? m_fl[m_fl_head] : '0, "dispatch_tnew");
    endtask

    task automatic advance_model();
        int                 n;
        int                 idx;
        int                 young;
        logic               rec;
        logic [pr_bits-1:0] tnew;
        n = retire_num();
        rec = recovers(n);
        tnew = (dispatch_arch_reg != 0) ? m_fl[m_fl_head] : '0;  // read before any push
        for (int i = 0; i < n; i++) begin
            idx = (m_head + i) % rob_size;
            if (m_ar[idx] != 0) begin
                m_map[m_ar[idx]] = m_tnew[idx];
                m_fl[m_fl_tail] = m_told[idx];  // told back in age order
                m_fl_tail = (m_fl_tail + 1) % fl_size;
            end
        end
        if (rec) begin
            young = 0;
            for (int i = n; i < m_count; i++) begin
                if (m_ar[(m_head + i) % rob_size] != 0)
                    young++;  // flushed writer, its tnew goes back
            end
            m_fl_head = (m_fl_head + fl_size - young) % fl_size;
            spec_map = m_map;
            m_head = 0;
            m_count = 0;  // dispatch in this cycle is dropped too
        end
        else begin
            if (dispatch_en && m_count < rob_size) begin
                idx = tail_idx();
                m_done[idx] = 1'b0;
                m_bad[idx] = 1'b0;
                m_ar[idx] = dispatch_arch_reg;
                m_tnew[idx] = tnew;
                m_told[idx] = dispatch_told;
                m_pc[idx] = '0;
                if (dispatch_arch_reg != 0) begin
                    spec_map[dispatch_arch_reg] = tnew;
                    m_fl_head = (m_fl_head + 1) % fl_size;
                end
                m_count++;
            end
            m_head = (m_head + n) % rob_size;
            m_count = m_count - n;
        end
        if (complete_en) begin
            m_done[complete_rob_idx] = 1'b1;
            m_bad[complete_rob_idx] = complete_mispredict;
            m_pc[complete_rob_idx] = complete_target_pc;
        end
    endtask

    // compare just ahead of the rising edge, inputs settled since the fall
    always begin
        @(negedge clock);
        #4;
        if (reset) begin
            model_reset();
        end
        else begin
            compare_outputs();
            advance_model();
        end
    end

    task automatic set_inputs(input logic d_en, input logic [ar_bits-1:0] ar, input logic c_en,
                              input logic [rob_bits-1:0] cidx, input logic bad,
                              input logic [xlen-1:0] pc);
        dispatch_en         = d_en;
        dispatch_arch_reg   = ar;
        dispatch_told       = spec_map[ar];  // caller supplies the old mapping
        complete_en         = c_en;
        complete_rob_idx    = cidx;
        complete_mispredict = bad;
        complete_target_pc  = pc;
    endtask

    task automatic step(input logic d_en, input logic [ar_bits-1:0] ar, input logic c_en,
                        input logic [rob_bits-1:0] cidx, input logic bad,
                        input logic [xlen-1:0] pc);
        @(negedge clock);
        set_inputs(d_en, ar, c_en, cidx, bad, pc);
    endtask

    task automatic dispatch_one(input logic [ar_bits-1:0] ar, output logic [rob_bits-1:0] idx,
                                output logic [pr_bits-1:0] tnew);
        step(1'b1, ar, 1'b0, '0, 1'b0, '0);
        idx = rob_bits'(tail_idx());
        tnew = (ar != 0) ? m_fl[m_fl_head] : '0;
    endtask

    task automatic drain();
        int t;
        t = 0;
        while (m_count != 0 && t < 100) begin
            step(1'b0, '0, 1'b0, '0, 1'b0, '0);
            t++;
        end
        if (m_count != 0)
            report_timeout("reorder buffer never drained");
    endtask

    initial begin
        int                  wr_ar [6];
        int                  done_order [6];
        logic [pr_bits-1:0]  reuse_exp [7];
        logic [rob_bits-1:0] b [4];
        logic [pr_bits-1:0]  tn [4];
        logic [rob_bits-1:0] prev;
        logic                d_en;
        logic                c_en;
        logic [rob_bits-1:0] cidx;
        int                  t;
        wr_ar = '{1, 2, 1, 3, 2, 4};
        done_order = '{5, 3, 1, 0, 4, 2};
        reuse_exp = '{6'd1, 6'd2, 6'd32, 6'd3, 6'd33, 6'd4, 6'd5};  // tolds in retire order
        seed = 32'hd907;
        errors = 0;
        clock = 1'b0;
        reset = 1'b1;
        prev = '0;
        model_reset();
        set_inputs(1'b0, '0, 1'b0, '0, 1'b0, '0);
        repeat (10) @(negedge clock);
        reset = 1'b0;

        // reset state
        #1;
        for (int i = 0; i < ar_num; i++)
            check(arch_map[i], i, "identity map after reset");
        check(retire_count, 0, "retire_count after reset");
        check(recover_en, 0, "recover_en after reset");

        // six writers, completed out of order
        for (int i = 0; i < 6; i++) begin
            step(1'b1, ar_bits'(wr_ar[i]), 1'b0, '0, 1'b0, '0);
            #1;
            if (i == 0)
                check(dispatch_tnew, 32, "first writer tnew");
        end
        for (int i = 0; i < 6; i++)
            step(1'b0, '0, 1'b1, rob_bits'(done_order[i]), 1'b0, '0);
        drain();
        check(arch_map[1], 34, "r1 last tnew");
        check(arch_map[2], 36, "r2 last tnew");
        check(arch_map[3], 35, "r3 last tnew");
        check(arch_map[4], 37, "r4 last tnew");

        // register zero takes no free register
        dispatch_one(5'd0, b[0], tn[0]);
        #1 check(dispatch_tnew, 0, "r0 tnew");
        dispatch_one(5'd0, b[1], tn[1]);
        dispatch_one(5'd5, b[2], tn[2]);
        #1 check(dispatch_tnew, 38, "tnew after r0 dispatches");
        for (int i = 0; i < 3; i++)
            step(1'b0, '0, 1'b1, b[i], 1'b0, '0);
        drain();
        check(arch_map[0], 0, "r0 mapping");
        check(arch_map[5], 38, "r5 mapping");

        // wrap the free list, retired tolds come back out
        for (int i = 0; i < 32; i++) begin
            step(1'b1, 5'd7, i > 0, prev, 1'b0, '0);
            prev = rob_bits'(tail_idx());
            #1;
            if (i >= 25)
                check(dispatch_tnew, reuse_exp[i - 25], "reused tnew");
        end
        step(1'b0, '0, 1'b1, prev, 1'b0, '0);
        drain();

        // branch in the middle of the head group
        for (int i = 0; i < 4; i++)
            dispatch_one(ar_bits'(8 + i), b[i], tn[i]);
        step(1'b0, '0, 1'b1, b[2], 1'b0, '0);
        step(1'b0, '0, 1'b1, b[3], 1'b0, '0);
        step(1'b0, '0, 1'b1, b[1], 1'b1, 32'h0000_4a40);
        step(1'b0, '0, 1'b1, b[0], 1'b0, '0);
        t = 0;
        do begin
            step(1'b0, '0, 1'b0, '0, 1'b0, '0);
            #1;
            t++;
        end while (!recover_en && t < 8);
        if (!recover_en)
            report_timeout("no recovery after the mispredict completed");
        check(target_pc, 32'h0000_4a40, "redirect pc");
        check(retire_count, 2, "retire_count at recovery");
        check(recover_maptable[8], tn[0], "recovered r8");
        check(recover_maptable[9], tn[1], "recovered r9");
        check(recover_maptable[10], 10, "r10 not recovered");
        check(recover_maptable[11], 11, "r11 not recovered");
        dispatch_one(5'd12, b[0], tn[0]);
        #1 check(dispatch_tnew, tn[2], "tnew after head rewind");  // first flushed writer
        step(1'b0, '0, 1'b1, b[0], 1'b0, '0);
        drain();

        // fill the rob, a dispatch while full is dropped
        for (int i = 0; i < rob_size; i++) begin
            dispatch_one(5'd13, b[0], tn[0]);
            if (i == 0)
                prev = b[0];  // oldest entry
        end
        step(1'b1, 5'd14, 1'b0, '0, 1'b0, '0);
        #1 check(rob_full, 1, "rob_full with every slot taken");
        step(1'b0, '0, 1'b1, prev, 1'b1, 32'h0000_1c00);  // flush 31 writers
        drain();

        // random traffic
        for (int c = 0; c < 2000; c++) begin
            @(negedge clock);
            d_en = (($random(seed) & 1) != 0) && (m_count < rob_size);
            c_en = 1'b0;
            cidx = '0;
            if (m_count > 0) begin
                cidx = rob_bits'((m_head + (($random(seed) & 32'h7fff_ffff) % m_count)) % rob_size);
                c_en = !m_done[cidx] && (($random(seed) & 3) != 0);
            end
            set_inputs(d_en, ar_bits'($random(seed)), c_en, cidx,
                       ($random(seed) & 15) == 0, $random(seed));
        end
        step(1'b0, '0, 1'b0, '0, 1'b0, '0);
        step(1'b0, '0, 1'b0, '0, 1'b0, '0);

        $display("checks done, %0d errors", errors);
        if (errors == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

endmodule

//--- hdl/arch_map_table.sv
`timescale 1ns/1ps

module arch_map_table (
    input  logic                                                    clock,
    input  logic                                                    reset,
    input  logic [retire_pkg::retire_width-1:0]                     retire_en,
    input  logic [retire_pkg::retire_width-1:0][retire_pkg::ar_bits-1:0] map_ar,
    input  logic [retire_pkg::retire_width-1:0][retire_pkg::pr_bits-1:0] map_ar_pr,
    output logic [retire_pkg::ar_num-1:0][retire_pkg::pr_bits-1:0]  archi_maptable
);
    import retire_pkg::*;

    logic [ar_num-1:0][pr_bits-1:0] map_q;
    logic [ar_num-1:0][pr_bits-1:0] map_d;

    assign archi_maptable = map_q;

    // oldest first, index 0 is youngest and lands last
    always_comb begin
        map_d = map_q;
        for (int k = retire_width - 1; k >= 0; k--) begin
            if (retire_en[k])
                map_d[map_ar[k]] = map_ar_pr[k];
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < ar_num; i++)
                map_q[i] <= pr_bits'(i);  // identity, p0..p31
        end
        else begin
            map_q <= map_d;
        end
    end

endmodule

//--- hdl/free_list.sv
`timescale 1ns/1ps

module free_list (
    input  logic                           clock,
    input  logic                           reset,
    input  logic                           alloc_en,  // pop one at head
    output logic [retire_pkg::pr_bits-1:0] alloc_pr,
    freelist_if.freelist                   fl
);
    import retire_pkg::*;

    logic [pr_bits-1:0]  fl_mem [fl_size];
    logic [rob_bits-1:0] head;                     // next reg handed out
    logic [rob_bits-1:0] tail;                     // next slot for a returned told
    logic [rob_bits-1:0] push_ptr [retire_width];
    logic [rob_bits-1:0] tail_next;

    assign alloc_pr         = fl_mem[head];
    assign fl.freelist_head = head;

    // slot for each returning told, oldest takes the first one
    always_comb begin
        tail_next = tail;
        for (int k = retire_width - 1; k >= 0; k--) begin
            push_ptr[k] = tail_next;
            if (fl.retire_en[k])
                tail_next = tail_next + rob_bits'(1);
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            head <= '0;
            tail <= '0;  // head == tail, full
            for (int i = 0; i < fl_size; i++)
                fl_mem[i] <= pr_bits'((1 << pr_bits) - fl_size + i);  // p32..p63
        end
        else begin
            if (fl.recover_en)
                head <= fl.recover_head;  // hand back regs of flushed writers
            else if (alloc_en)
                head <= head + rob_bits'(1);
            // retired tolds commit even on a recovery edge
            tail <= tail_next;
            for (int k = 0; k < retire_width; k++) begin
                if (fl.retire_en[k])
                    fl_mem[push_ptr[k]] <= fl.tolds[k];
            end
        end
    end

endmodule

//--- hdl/freelist_if.sv
`timescale 1ns/1ps

interface freelist_if;
    import retire_pkg::*;

    logic [retire_width-1:0]              retire_en;      // only slots that wrote a reg
    logic [retire_width-1:0][pr_bits-1:0] tolds;
    logic                                 recover_en;
    logic [rob_bits-1:0]                  recover_head;   // rewound alloc pointer
    logic [rob_bits-1:0]                  freelist_head;  // current alloc pointer

    modport retire (
        output retire_en, tolds, recover_en, recover_head,
        input  freelist_head
    );

    modport freelist (
        input  retire_en, tolds, recover_en, recover_head,
        output freelist_head
    );

endinterface

//--- hdl/reorder_buffer.sv
`timescale 1ns/1ps

module reorder_buffer (
    input  logic                           clock,
    input  logic                           reset,
    // dispatch, one per cycle
    input  logic                           dispatch_en,
    input  logic [retire_pkg::ar_bits-1:0] dispatch_arch_reg,
    input  logic [retire_pkg::pr_bits-1:0] dispatch_told,
    input  logic [retire_pkg::pr_bits-1:0] dispatch_tnew,   // from free list
    output logic [retire_pkg::rob_bits-1:0] dispatch_rob_idx,
    output logic                           rob_full,
    // completion strobe
    input  logic                           complete_en,
    input  logic [retire_pkg::rob_bits-1:0] complete_rob_idx,
    input  logic                           complete_mispredict,
    input  logic [retire_pkg::xlen-1:0]    complete_target_pc,
    output logic [1:0]                     retire_count,
    rob_retire_if.rob                      rob
);
    import retire_pkg::*;

    rob_entry_packet     rob_mem [rob_size];  // payload, no reset
    logic [rob_bits-1:0] head;
    logic [rob_bits-1:0] tail;
    logic [rob_bits:0]   count;               // needs to reach rob_size
    logic [rob_bits-1:0] writers;             // running count of reg writers
    logic [rob_bits-1:0] head_idx [retire_width];
    logic                dispatch_fire;
    logic                dispatch_writer;
    logic [1:0]          retire_num;
    logic [1:0]          retire_writers;

    assign rob_full         = (count == (rob_bits+1)'(rob_size));
    assign dispatch_fire    = dispatch_en && !rob_full;  // dispatch while full dropped
    assign dispatch_writer  = dispatch_fire && (dispatch_arch_reg != '0);
    assign dispatch_rob_idx = tail;
    assign rob.fl_distance  = writers;
    assign retire_count     = retire_num;

    // head view, oldest at the top index
    always_comb begin
        for (int k = 0; k < retire_width; k++) begin
            head_idx[k] = head + rob_bits'(retire_width - 1 - k);
            rob.rob_head_entry[k] = rob_mem[head_idx[k]];
            // slots past the count never look completed
            rob.rob_head_entry[k].completed = rob_mem[head_idx[k]].completed &&
                                              (count > (rob_bits+1)'(retire_width - 1 - k));
        end
    end

    // popcounts of what leaves this cycle
    always_comb begin
        retire_num     = '0;
        retire_writers = '0;
        for (int k = 0; k < retire_width; k++) begin
            if (rob.retire_valid[k]) begin
                retire_num = retire_num + 2'd1;
                if (rob.rob_head_entry[k].arch_reg != '0)
                    retire_writers = retire_writers + 2'd1;  // its tnew went out of the free list
            end
        end
    end

    // pointers and counts
    always_ff @(posedge clock) begin
        if (reset || rob.recover_en) begin  // flush drops every younger entry
            head    <= '0;
            tail    <= '0;
            count   <= '0;
            writers <= '0;
        end
        else begin
            head    <= head + rob_bits'(retire_num);
            tail    <= tail + rob_bits'(dispatch_fire);
            count   <= count + (rob_bits+1)'(dispatch_fire) - (rob_bits+1)'(retire_num);
            writers <= writers + rob_bits'(dispatch_writer) - rob_bits'(retire_writers);
        end
    end

    // entry payload
    always_ff @(posedge clock) begin
        if (dispatch_fire && !rob.recover_en) begin
            rob_mem[tail].completed          <= 1'b0;
            rob_mem[tail].precise_state_need <= 1'b0;
            rob_mem[tail].arch_reg           <= dispatch_arch_reg;
            rob_mem[tail].tnew               <= dispatch_tnew;
            rob_mem[tail].told               <= dispatch_told;
            rob_mem[tail].target_pc          <= '0;
        end
        if (complete_en) begin  // later nba, wins on a same-slot collision
            rob_mem[complete_rob_idx].completed          <= 1'b1;
            rob_mem[complete_rob_idx].precise_state_need <= complete_mispredict;
            rob_mem[complete_rob_idx].target_pc          <= complete_target_pc;
        end
    end

endmodule

//--- hdl/retire_pkg.sv
package retire_pkg;

    // widths
    localparam int xlen         = 32;   // pc width
    localparam int pr_bits      = 6;    // 64 physical regs
    localparam int ar_bits      = 5;    // 32 architectural regs
    localparam int rob_bits     = 5;    // rob index, also free list ptr / distance

    // sizes
    localparam int rob_size     = 32;
    localparam int fl_size      = 32;   // same depth as rob so no underflow
    localparam int retire_width = 3;
    localparam int ar_num       = 1 << ar_bits;

    // one reorder buffer slot
    // completed doubles as the valid bit on the head view
    typedef struct packed {
        logic               completed;
        logic               precise_state_need;  // mispredicted branch
        logic [ar_bits-1:0] arch_reg;            // 0 means no reg write
        logic [pr_bits-1:0] tnew;
        logic [pr_bits-1:0] told;                // goes back to free list on retire
        logic [xlen-1:0]    target_pc;           // redirect pc on recovery
    } rob_entry_packet;

endpackage

//--- hdl/retire_stage.sv
`timescale 1ns/1ps

module retire_stage (
    rob_retire_if.retire                                            rob,
    freelist_if.retire                                              fl,
    input  logic [retire_pkg::ar_num-1:0][retire_pkg::pr_bits-1:0]  archi_maptable,
    // arch map write ports, enables come from fl.retire_en
    output logic [retire_pkg::retire_width-1:0][retire_pkg::ar_bits-1:0] map_ar,
    output logic [retire_pkg::retire_width-1:0][retire_pkg::pr_bits-1:0] map_ar_pr,
    // recovery
    output logic [retire_pkg::ar_num-1:0][retire_pkg::pr_bits-1:0]  recover_maptable,
    output logic [retire_pkg::xlen-1:0]                             target_pc
);
    import retire_pkg::*;

    logic                still_going;     // no stop seen yet in the walk
    logic                recover;
    logic [rob_bits-1:0] retire_writers;  // writers leaving this cycle
    logic [rob_bits-1:0] young_writers;   // writers that get flushed

    // per-slot fields, retire_en limited to real reg writes
    always_comb begin
        for (int k = 0; k < retire_width; k++) begin
            map_ar[k]       = rob.rob_head_entry[k].arch_reg;
            map_ar_pr[k]    = rob.rob_head_entry[k].tnew;
            fl.tolds[k]     = rob.rob_head_entry[k].told;
            fl.retire_en[k] = rob.retire_valid[k] && (rob.rob_head_entry[k].arch_reg != '0);
        end
    end

    // walk oldest -> youngest
    always_comb begin
        still_going      = 1'b1;
        recover          = 1'b0;
        rob.retire_valid = '0;
        retire_writers   = '0;
        target_pc        = '0;
        recover_maptable = archi_maptable;  // start from committed state
        for (int k = retire_width - 1; k >= 0; k--) begin
            if (still_going && rob.rob_head_entry[k].completed) begin
                rob.retire_valid[k] = 1'b1;
                if (rob.rob_head_entry[k].arch_reg != '0) begin
                    // overlay oldest first so younger writes land on top
                    recover_maptable[rob.rob_head_entry[k].arch_reg] =
                        rob.rob_head_entry[k].tnew;
                    retire_writers = retire_writers + rob_bits'(1);
                end
                if (rob.rob_head_entry[k].precise_state_need) begin
                    recover     = 1'b1;
                    target_pc   = rob.rob_head_entry[k].target_pc;
                    still_going = 1'b0;  // mispredict retires, nothing after it
                end
            end
            else begin
                still_going = 1'b0;  // in order, first incomplete blocks the rest
            end
        end
    end

    assign rob.recover_en = recover;
    assign fl.recover_en  = recover;

    // every flushed writer popped one free reg, so rewind head by that many
    assign young_writers   = rob.fl_distance - retire_writers;
    assign fl.recover_head = fl.freelist_head - young_writers;  // mod fl_size by width

endmodule

//--- hdl/retire_top.sv
`timescale 1ns/1ps

module retire_top (
    input  logic                                                   clock,
    input  logic                                                   reset,
    input  logic                                                   dispatch_en,
    input  logic [retire_pkg::ar_bits-1:0]                         dispatch_arch_reg,
    input  logic [retire_pkg::pr_bits-1:0]                         dispatch_told,
    output logic [retire_pkg::pr_bits-1:0]                         dispatch_tnew,
    output logic [retire_pkg::rob_bits-1:0]                        dispatch_rob_idx,
    output logic                                                   rob_full,
    input  logic                                                   complete_en,
    input  logic [retire_pkg::rob_bits-1:0]                        complete_rob_idx,
    input  logic                                                   complete_mispredict,
    input  logic [retire_pkg::xlen-1:0]                            complete_target_pc,
    output logic                                                   recover_en,
    output logic [retire_pkg::xlen-1:0]                            target_pc,
    output logic [retire_pkg::ar_num-1:0][retire_pkg::pr_bits-1:0] recover_maptable,
    output logic [1:0]                                             retire_count,
    output logic [retire_pkg::ar_num-1:0][retire_pkg::pr_bits-1:0] arch_map
);
    import retire_pkg::*;

    rob_retire_if rob_bus ();
    freelist_if   fl_bus ();

    logic                                 alloc_en;
    logic [pr_bits-1:0]                   alloc_pr;
    logic [retire_width-1:0][ar_bits-1:0] map_ar;
    logic [retire_width-1:0][pr_bits-1:0] map_ar_pr;

    assign alloc_en      = dispatch_en && (dispatch_arch_reg != '0) && !rob_full;
    assign dispatch_tnew = (dispatch_arch_reg != '0) ? alloc_pr : '0;  // r0 maps to p0
    assign recover_en    = rob_bus.recover_en;

    reorder_buffer u_rob (
        .clock, .reset,
        .dispatch_en, .dispatch_arch_reg, .dispatch_told, .dispatch_tnew,
        .dispatch_rob_idx, .rob_full,
        .complete_en, .complete_rob_idx, .complete_mispredict, .complete_target_pc,
        .retire_count,
        .rob (rob_bus.rob)
    );

    retire_stage u_retire (
        .rob (rob_bus.retire),
        .fl  (fl_bus.retire),
        .archi_maptable (arch_map),
        .map_ar, .map_ar_pr, .recover_maptable, .target_pc
    );

    arch_map_table u_arch_map (
        .clock, .reset,
        .retire_en (fl_bus.retire_en),
        .map_ar, .map_ar_pr,
        .archi_maptable (arch_map)
    );

    free_list u_free_list (
        .clock, .reset, .alloc_en, .alloc_pr,
        .fl (fl_bus.freelist)
    );

endmodule

//--- hdl/rob_retire_if.sv
`timescale 1ns/1ps

// head group and retire decision between rob and retire stage
// index 2 is always the oldest slot
interface rob_retire_if;
    import retire_pkg::*;

    rob_entry_packet [retire_width-1:0] rob_head_entry;
    logic [rob_bits-1:0]                fl_distance;   // reg writers still in rob
    logic [retire_width-1:0]            retire_valid;  // slots leaving, incl. reg zero
    logic                               recover_en;    // flush the rob

    modport rob (
        output rob_head_entry,
        output fl_distance,
        input  retire_valid,
        input  recover_en
    );

    modport retire (
        input  rob_head_entry,
        input  fl_distance,
        output retire_valid,
        output recover_en
    );

endinterface

//--- run.sh
#!/bin/sh
# build and run the retire stage testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module retire_tb -f tb.f -o retire_sim
./obj_dir/retire_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "test failed" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi
echo "simulation finished without failure"

//--- tb.f
hdl/retire_pkg.sv
hdl/rob_retire_if.sv
hdl/freelist_if.sv
hdl/reorder_buffer.sv
hdl/retire_stage.sv
hdl/arch_map_table.sv
hdl/free_list.sv
hdl/retire_top.sv
bench/retire_tb.sv
